/* verilog/pcu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants of the performance counter unit
// SPR map, PCMR bit layout and event vector order
// Referenced by scoped names from every RTL block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pcu_pkg;

  // Number of counter / mode register pairs
  localparam int PCU_NUM = 8;
  localparam int PCU_IDX_W = $clog2(PCU_NUM);

  // Event strobes reported by the core
  localparam int EVT_NUM = 11;

  // Bit order of the event vector
  localparam int EVT_LOAD          = 0;
  localparam int EVT_STORE         = 1;
  localparam int EVT_IFETCH        = 2;
  localparam int EVT_DCACHE_MISS   = 3;
  localparam int EVT_ICACHE_MISS   = 4;
  localparam int EVT_IFETCH_STALL  = 5;
  localparam int EVT_LSU_STALL     = 6;
  localparam int EVT_BRN_STALL     = 7;
  localparam int EVT_DTLB_MISS     = 8;
  localparam int EVT_ITLB_MISS     = 9;
  localparam int EVT_DATADEP_STALL = 10;

  // SPR bus widths
  localparam int SPR_ADDR_W = 16;
  localparam int SPR_DAT_W  = 32;

  // Group number sits in address bits 15:11, offset below it
  localparam int SPR_GROUP_LSB = 11;
  localparam int SPR_GROUP_W   = SPR_ADDR_W - SPR_GROUP_LSB;
  localparam logic [SPR_GROUP_W-1:0] SPR_GROUP_PCU = 5'd7;

  // Base offsets, counter n at base + n
  localparam logic [SPR_GROUP_LSB-1:0] SPR_OFS_PCCR = 11'h000;
  localparam logic [SPR_GROUP_LSB-1:0] SPR_OFS_PCMR = 11'h008;

  // PCMR layout
  localparam int PCMR_CP      = 0;
  localparam int PCMR_CISM    = 1;
  localparam int PCMR_CIUM    = 2;
  localparam int PCMR_EVT_LSB = 3;
  localparam int PCMR_WIDTH   = 14;

endpackage

/* verilog/pcu_event_sampler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 1 of the event pipeline
// Packs the core strobes into one vector and registers it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcu_event_sampler (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       evt_load_i,
  input  logic                       evt_store_i,
  input  logic                       evt_ifetch_i,
  input  logic                       evt_dcache_miss_i,
  input  logic                       evt_icache_miss_i,
  input  logic                       evt_ifetch_stall_i,
  input  logic                       evt_lsu_stall_i,
  input  logic                       evt_brn_stall_i,
  input  logic                       evt_dtlb_miss_i,
  input  logic                       evt_itlb_miss_i,
  input  logic                       evt_datadep_stall_i,
  input  logic                       sys_mode_i,
  output logic [pcu_pkg::EVT_NUM-1:0] evt_vec_o,
  output logic                       sys_mode_o
);

  logic [pcu_pkg::EVT_NUM-1:0] evt_vec;

  // Order must match the PCMR enable bits
  always_comb begin
    evt_vec                              = '0;
    evt_vec[pcu_pkg::EVT_LOAD]           = evt_load_i;
    evt_vec[pcu_pkg::EVT_STORE]          = evt_store_i;
    evt_vec[pcu_pkg::EVT_IFETCH]         = evt_ifetch_i;
    evt_vec[pcu_pkg::EVT_DCACHE_MISS]    = evt_dcache_miss_i;
    evt_vec[pcu_pkg::EVT_ICACHE_MISS]    = evt_icache_miss_i;
    evt_vec[pcu_pkg::EVT_IFETCH_STALL]   = evt_ifetch_stall_i;
    evt_vec[pcu_pkg::EVT_LSU_STALL]      = evt_lsu_stall_i;
    evt_vec[pcu_pkg::EVT_BRN_STALL]      = evt_brn_stall_i;
    evt_vec[pcu_pkg::EVT_DTLB_MISS]      = evt_dtlb_miss_i;
    evt_vec[pcu_pkg::EVT_ITLB_MISS]      = evt_itlb_miss_i;
    evt_vec[pcu_pkg::EVT_DATADEP_STALL]  = evt_datadep_stall_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      evt_vec_o  <= '0;
      sys_mode_o <= 1'b0;
    end else begin
      evt_vec_o  <= evt_vec;
      sys_mode_o <= sys_mode_i;
    end
  end

endmodule

/* verilog/pcu_event_filter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 2 of the event pipeline
// Applies each counter's mode and event masks to the sampled
// vector and registers one increment request per counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcu_event_filter (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [pcu_pkg::EVT_NUM-1:0]                   evt_vec_i,
  input  logic                                          sys_mode_i,
  input  logic [pcu_pkg::PCU_NUM*pcu_pkg::PCMR_WIDTH-1:0] pcmr_flat_i,
  output logic [pcu_pkg::PCU_NUM-1:0]                   inc_req_o
);

  localparam int W = pcu_pkg::PCMR_WIDTH;

  logic [pcu_pkg::PCU_NUM-1:0] evt_hit;
  logic [pcu_pkg::PCU_NUM-1:0] mode_ok;
  logic [pcu_pkg::PCU_NUM-1:0] inc_req;

  genvar n;
  generate
    for (n = 0; n < pcu_pkg::PCU_NUM; n = n + 1) begin : g_cnt
      logic [W-1:0]                pcmr;
      logic [pcu_pkg::EVT_NUM-1:0] evt_en;

      assign pcmr   = pcmr_flat_i[n*W +: W];
      assign evt_en = pcmr[pcu_pkg::PCMR_EVT_LSB +: pcu_pkg::EVT_NUM];

      // Any enabled event counts once per cycle
      assign evt_hit[n] = |(evt_vec_i & evt_en);

      // CISM qualifies supervisor cycles, CIUM user cycles
      assign mode_ok[n] = sys_mode_i ? pcmr[pcu_pkg::PCMR_CISM]
                                     : pcmr[pcu_pkg::PCMR_CIUM];

      assign inc_req[n] = evt_hit[n] & mode_ok[n];
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst) begin
      inc_req_o <= '0;
    end else begin
      inc_req_o <= inc_req;
    end
  end

endmodule

/* verilog/pcu_counter_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 3 of the event pipeline
// Holds the PCCR counters, applies increments and preset writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcu_counter_bank (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [pcu_pkg::PCU_NUM-1:0]                  inc_req_i,
  input  logic [pcu_pkg::PCU_NUM-1:0]                  pccr_we_i,
  input  logic [pcu_pkg::SPR_DAT_W-1:0]                pccr_wdat_i,
  output logic [pcu_pkg::PCU_NUM*pcu_pkg::SPR_DAT_W-1:0] pccr_flat_o
);

  localparam int DW = pcu_pkg::SPR_DAT_W;

  logic [DW-1:0] pccr_q [pcu_pkg::PCU_NUM];

  genvar n;
  generate
    for (n = 0; n < pcu_pkg::PCU_NUM; n = n + 1) begin : g_cnt
      logic [DW-1:0] pccr_next;

      // Preset write takes priority, a coincident increment is dropped
      always_comb begin
        if (pccr_we_i[n]) begin
          pccr_next = pccr_wdat_i;
        end else if (inc_req_i[n]) begin
          // Wraps modulo 2^32
          pccr_next = pccr_q[n] + 1'b1;
        end else begin
          pccr_next = pccr_q[n];
        end
      end

      always_ff @(posedge clk) begin
        if (rst) begin
          pccr_q[n] <= '0;
        end else begin
          pccr_q[n] <= pccr_next;
        end
      end

      assign pccr_flat_o[n*DW +: DW] = pccr_q[n];
    end
  endgenerate

endmodule

/* verilog/pcu_spr_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPR side of the performance counter unit
// Decodes accesses, holds the PCMRs, checks privilege and
// returns read data with a same-cycle acknowledge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcu_spr_regs (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           spr_access_i,
  input  logic                                           spr_we_i,
  input  logic                                           spr_re_i,
  input  logic [pcu_pkg::SPR_ADDR_W-1:0]                 spr_addr_i,
  input  logic [pcu_pkg::SPR_DAT_W-1:0]                  spr_dat_i,
  input  logic                                           spr_sys_mode_i,
  output logic                                           spr_ack_o,
  output logic [pcu_pkg::SPR_DAT_W-1:0]                  spr_dat_o,
  input  logic [pcu_pkg::PCU_NUM*pcu_pkg::SPR_DAT_W-1:0]  pccr_flat_i,
  output logic [pcu_pkg::PCU_NUM*pcu_pkg::PCMR_WIDTH-1:0] pcmr_flat_o,
  output logic [pcu_pkg::PCU_NUM-1:0]                    pccr_we_o,
  output logic [pcu_pkg::SPR_DAT_W-1:0]                  pccr_wdat_o
);

  localparam int W   = pcu_pkg::PCMR_WIDTH;
  localparam int DW  = pcu_pkg::SPR_DAT_W;
  localparam int OW  = pcu_pkg::SPR_GROUP_LSB;
  localparam int IW  = pcu_pkg::PCU_IDX_W;
  localparam int SLB = pcu_pkg::PCMR_CP + 1;

  logic [pcu_pkg::SPR_GROUP_W-1:0] group;
  logic [OW-1:0]                   pccr_rel;
  logic [OW-1:0]                   pcmr_rel;
  logic                            group_hit;
  logic                            pccr_hit;
  logic                            pcmr_hit;
  logic [IW-1:0]                   pccr_idx;
  logic [IW-1:0]                   pcmr_idx;
  logic                            wr_ok;
  logic                            rd_en;

  // CP is not stored, it is forced on the way out
  logic [W-1:SLB] pcmr_q    [pcu_pkg::PCU_NUM];
  logic [W-1:0]   pcmr_word [pcu_pkg::PCU_NUM];

  assign group     = spr_addr_i[pcu_pkg::SPR_ADDR_W-1:OW];
  assign group_hit = (group == pcu_pkg::SPR_GROUP_PCU);

  // Offsets below a base wrap to large values and miss
  assign pccr_rel = spr_addr_i[OW-1:0] - pcu_pkg::SPR_OFS_PCCR;
  assign pcmr_rel = spr_addr_i[OW-1:0] - pcu_pkg::SPR_OFS_PCMR;
  assign pccr_hit = group_hit && (pccr_rel < OW'(pcu_pkg::PCU_NUM));
  assign pcmr_hit = group_hit && (pcmr_rel < OW'(pcu_pkg::PCU_NUM));
  assign pccr_idx = pccr_rel[IW-1:0];
  assign pcmr_idx = pcmr_rel[IW-1:0];

  // Writes only land in supervisor mode
  assign wr_ok = spr_access_i & spr_we_i & spr_sys_mode_i;
  assign rd_en = spr_access_i & spr_re_i;

  assign spr_ack_o   = spr_access_i;
  assign pccr_wdat_o = spr_dat_i;

  genvar n;
  generate
    for (n = 0; n < pcu_pkg::PCU_NUM; n = n + 1) begin : g_reg
      assign pccr_we_o[n] = wr_ok & pccr_hit & (pccr_idx == IW'(n));

      always_ff @(posedge clk) begin
        if (rst) begin
          pcmr_q[n] <= '0;
        end else if (wr_ok && pcmr_hit && (pcmr_idx == IW'(n))) begin
          pcmr_q[n] <= spr_dat_i[W-1:SLB];
        end
      end

      assign pcmr_word[n]            = {pcmr_q[n], 1'b1};
      assign pcmr_flat_o[n*W +: W]   = pcmr_word[n];
    end
  endgenerate

  // Read mux, PCMR only visible in supervisor mode
  always_comb begin
    spr_dat_o = '0;
    if (rd_en && pccr_hit) begin
      spr_dat_o = pccr_flat_i[pccr_idx*DW +: DW];
    end else if (rd_en && pcmr_hit && spr_sys_mode_i) begin
      spr_dat_o = {{(DW-W){1'b0}}, pcmr_word[pcmr_idx]};
    end
  end

endmodule

/* verilog/pcu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Performance counter unit top level
// Connects the event pipeline to the SPR register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcu_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          spr_access_i,
  input  logic                          spr_we_i,
  input  logic                          spr_re_i,
  input  logic [pcu_pkg::SPR_ADDR_W-1:0] spr_addr_i,
  input  logic [pcu_pkg::SPR_DAT_W-1:0]  spr_dat_i,
  input  logic                          spr_sys_mode_i,
  output logic                          spr_ack_o,
  output logic [pcu_pkg::SPR_DAT_W-1:0]  spr_dat_o,
  input  logic                          evt_load_i,
  input  logic                          evt_store_i,
  input  logic                          evt_ifetch_i,
  input  logic                          evt_dcache_miss_i,
  input  logic                          evt_icache_miss_i,
  input  logic                          evt_ifetch_stall_i,
  input  logic                          evt_lsu_stall_i,
  input  logic                          evt_brn_stall_i,
  input  logic                          evt_dtlb_miss_i,
  input  logic                          evt_itlb_miss_i,
  input  logic                          evt_datadep_stall_i
);

  logic [pcu_pkg::EVT_NUM-1:0]                    evt_vec;
  logic                                           sys_mode;
  logic [pcu_pkg::PCU_NUM*pcu_pkg::PCMR_WIDTH-1:0] pcmr_flat;
  logic [pcu_pkg::PCU_NUM-1:0]                    inc_req;
  logic [pcu_pkg::PCU_NUM-1:0]                    pccr_we;
  logic [pcu_pkg::SPR_DAT_W-1:0]                  pccr_wdat;
  logic [pcu_pkg::PCU_NUM*pcu_pkg::SPR_DAT_W-1:0]  pccr_flat;

  // Mode flag travels with the strobes through stage 1
  pcu_event_sampler i_sampler (
    .clk                 (clk),
    .rst                 (rst),
    .evt_load_i          (evt_load_i),
    .evt_store_i         (evt_store_i),
    .evt_ifetch_i        (evt_ifetch_i),
    .evt_dcache_miss_i   (evt_dcache_miss_i),
    .evt_icache_miss_i   (evt_icache_miss_i),
    .evt_ifetch_stall_i  (evt_ifetch_stall_i),
    .evt_lsu_stall_i     (evt_lsu_stall_i),
    .evt_brn_stall_i     (evt_brn_stall_i),
    .evt_dtlb_miss_i     (evt_dtlb_miss_i),
    .evt_itlb_miss_i     (evt_itlb_miss_i),
    .evt_datadep_stall_i (evt_datadep_stall_i),
    .sys_mode_i          (spr_sys_mode_i),
    .evt_vec_o           (evt_vec),
    .sys_mode_o          (sys_mode)
  );

  pcu_event_filter i_filter (
    .clk         (clk),
    .rst         (rst),
    .evt_vec_i   (evt_vec),
    .sys_mode_i  (sys_mode),
    .pcmr_flat_i (pcmr_flat),
    .inc_req_o   (inc_req)
  );

  pcu_counter_bank i_counters (
    .clk         (clk),
    .rst         (rst),
    .inc_req_i   (inc_req),
    .pccr_we_i   (pccr_we),
    .pccr_wdat_i (pccr_wdat),
    .pccr_flat_o (pccr_flat)
  );

  pcu_spr_regs i_spr (
    .clk            (clk),
    .rst            (rst),
    .spr_access_i   (spr_access_i),
    .spr_we_i       (spr_we_i),
    .spr_re_i       (spr_re_i),
    .spr_addr_i     (spr_addr_i),
    .spr_dat_i      (spr_dat_i),
    .spr_sys_mode_i (spr_sys_mode_i),
    .spr_ack_o      (spr_ack_o),
    .spr_dat_o      (spr_dat_o),
    .pccr_flat_i    (pccr_flat),
    .pcmr_flat_o    (pcmr_flat),
    .pccr_we_o      (pccr_we),
    .pccr_wdat_o    (pccr_wdat)
  );

endmodule

/* tests/pcu_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the SPR port of the counter unit
// Bound to pcu_top from the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcu_assert (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          spr_access_i,
  input  logic                          spr_re_i,
  input  logic [pcu_pkg::SPR_ADDR_W-1:0] spr_addr_i,
  input  logic                          spr_sys_mode_i,
  input  logic                          spr_ack_o,
  input  logic [pcu_pkg::SPR_DAT_W-1:0]  spr_dat_o
);

  logic pcmr_sel;

  // Number of failed properties so far
  int fail_cnt = 0;

  // Offsets 0x8 to 0xF of group 7
  assign pcmr_sel = (spr_addr_i[15:11] == pcu_pkg::SPR_GROUP_PCU) &&
                    (spr_addr_i[10:0] >= pcu_pkg::SPR_OFS_PCMR) &&
                    (spr_addr_i[10:0] < pcu_pkg::SPR_OFS_PCMR + pcu_pkg::PCU_NUM);

  a_ack_follows_access: assert property (
    @(posedge clk) disable iff (rst) spr_ack_o == spr_access_i
  ) else begin
    $error("spr_ack_o differs from spr_access_i");
    fail_cnt++;
  end

  a_dat_zero_no_read: assert property (
    @(posedge clk) disable iff (rst) !spr_re_i |-> (spr_dat_o == '0)
  ) else begin
    $error("spr_dat_o not zero without a read");
    fail_cnt++;
  end

  a_pcmr_hidden_in_user: assert property (
    @(posedge clk) disable iff (rst)
      (spr_access_i && spr_re_i && !spr_sys_mode_i && pcmr_sel) |-> (spr_dat_o == '0)
  ) else begin
    $error("PCMR visible in user mode");
    fail_cnt++;
  end

endmodule

/* tests/pcu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the performance counter unit
// Drives the SPR port and event strobes of pcu_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcu_tb;

  localparam int CLK_HALF = 2;
  // Cycle budget per test, reset first
  localparam int CYC_TOTAL = 12 + 40 + 30 + 70 + 60 + 40 + 140;
  localparam int TIMEOUT_CYC = 2 * CYC_TOTAL;

  localparam logic [31:0] M_CISM = 32'h1 << pcu_pkg::PCMR_CISM;
  localparam logic [31:0] M_CIUM = 32'h1 << pcu_pkg::PCMR_CIUM;
  localparam logic [pcu_pkg::EVT_NUM-1:0] E_LOAD  = 1 << pcu_pkg::EVT_LOAD;
  localparam logic [pcu_pkg::EVT_NUM-1:0] E_DMISS = 1 << pcu_pkg::EVT_DCACHE_MISS;

  logic                        clk;
  logic                        rst;
  logic                        spr_access;
  logic                        spr_we;
  logic                        spr_re;
  logic [15:0]                 spr_addr;
  logic [31:0]                 spr_dat_w;
  logic                        spr_sys_mode;
  logic                        spr_ack;
  logic [31:0]                 spr_dat_r;
  logic [pcu_pkg::EVT_NUM-1:0] evt;
  integer                      seed;

  pcu_top i_dut (
    .clk                 (clk),
    .rst                 (rst),
    .spr_access_i        (spr_access),
    .spr_we_i            (spr_we),
    .spr_re_i            (spr_re),
    .spr_addr_i          (spr_addr),
    .spr_dat_i           (spr_dat_w),
    .spr_sys_mode_i      (spr_sys_mode),
    .spr_ack_o           (spr_ack),
    .spr_dat_o           (spr_dat_r),
    .evt_load_i          (evt[pcu_pkg::EVT_LOAD]),
    .evt_store_i         (evt[pcu_pkg::EVT_STORE]),
    .evt_ifetch_i        (evt[pcu_pkg::EVT_IFETCH]),
    .evt_dcache_miss_i   (evt[pcu_pkg::EVT_DCACHE_MISS]),
    .evt_icache_miss_i   (evt[pcu_pkg::EVT_ICACHE_MISS]),
    .evt_ifetch_stall_i  (evt[pcu_pkg::EVT_IFETCH_STALL]),
    .evt_lsu_stall_i     (evt[pcu_pkg::EVT_LSU_STALL]),
    .evt_brn_stall_i     (evt[pcu_pkg::EVT_BRN_STALL]),
    .evt_dtlb_miss_i     (evt[pcu_pkg::EVT_DTLB_MISS]),
    .evt_itlb_miss_i     (evt[pcu_pkg::EVT_ITLB_MISS]),
    .evt_datadep_stall_i (evt[pcu_pkg::EVT_DATADEP_STALL])
  );

  bind pcu_top pcu_assert i_assert (
    .clk            (clk),
    .rst            (rst),
    .spr_access_i   (spr_access_i),
    .spr_re_i       (spr_re_i),
    .spr_addr_i     (spr_addr_i),
    .spr_sys_mode_i (spr_sys_mode_i),
    .spr_ack_o      (spr_ack_o),
    .spr_dat_o      (spr_dat_o)
  );

  always #(CLK_HALF) clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  function automatic logic [15:0] spr_address(input int grp, input int ofs);
    spr_address = {grp[4:0], ofs[10:0]};
  endfunction

  // One access cycle, data sampled 1 ns before the rising edge
  task automatic spr_read(input logic [15:0] addr, output logic [31:0] data);
    @(negedge clk);
    spr_access = 1'b1;
    spr_re     = 1'b1;
    spr_addr   = addr;
    #1;
    data = spr_dat_r;
    check("spr_ack_o", {31'b0, spr_ack}, 32'h1);
    @(negedge clk);
    spr_access = 1'b0;
    spr_re     = 1'b0;
  endtask

  task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
    @(negedge clk);
    spr_access = 1'b1;
    spr_we     = 1'b1;
    spr_addr   = addr;
    spr_dat_w  = data;
    #1;
    check("spr_ack_o", {31'b0, spr_ack}, 32'h1);
    @(negedge clk);
    spr_access = 1'b0;
    spr_we     = 1'b0;
  endtask

  task automatic read_check(input logic [15:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    spr_read(addr, data);
    check($sformatf("spr_dat_o @0x%04h", addr), data, exp);
  endtask

  task automatic set_mode(input logic sup);
    @(negedge clk);
    spr_sys_mode = sup;
  endtask

  // Pattern held for a number of cycles, then the pipeline drains
  task automatic pulse_events(input logic [pcu_pkg::EVT_NUM-1:0] pat, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      evt = pat;
    end
    @(negedge clk);
    evt = '0;
    repeat (4) @(negedge clk);
  endtask

  task automatic test_reset_values();
    set_mode(1'b1);
    for (int n = 0; n < pcu_pkg::PCU_NUM; n++) begin
      read_check(spr_address(7, pcu_pkg::SPR_OFS_PCCR + n), 32'h0);
      read_check(spr_address(7, pcu_pkg::SPR_OFS_PCMR + n), 32'h1);
    end
  endtask

  task automatic test_privilege();
    spr_write(spr_address(7, 0), 32'h0000_a5a5);
    set_mode(1'b0);
    read_check(spr_address(7, 8), 32'h0);
    read_check(spr_address(7, 0), 32'h0000_a5a5);
    spr_write(spr_address(7, 0), 32'h1234_0000);
    spr_write(spr_address(7, 8), 32'h0000_3ffe);
    set_mode(1'b1);
    read_check(spr_address(7, 0), 32'h0000_a5a5);
    read_check(spr_address(7, 8), 32'h1);
    spr_write(spr_address(7, 8), 32'h0);
    read_check(spr_address(7, 8), 32'h1);
  endtask

  task automatic test_mode_filter();
    int n_ld;
    int m_miss;
    n_ld   = 7;
    m_miss = 5;
    spr_write(spr_address(7, 0), 32'h0);
    spr_write(spr_address(7, 1), 32'h0);
    spr_write(spr_address(7, 8), M_CISM | (32'(E_LOAD) << pcu_pkg::PCMR_EVT_LSB));
    spr_write(spr_address(7, 9), M_CIUM | (32'(E_DMISS) << pcu_pkg::PCMR_EVT_LSB));
    read_check(spr_address(7, 8), M_CISM | (32'(E_LOAD) << pcu_pkg::PCMR_EVT_LSB) | 32'h1);
    pulse_events(E_LOAD, n_ld);
    // Supervisor misses must not reach counter 1
    pulse_events(E_DMISS, 3);
    set_mode(1'b0);
    pulse_events(E_DMISS, m_miss);
    pulse_events(E_LOAD, 4);
    set_mode(1'b1);
    read_check(spr_address(7, 0), n_ld);
    read_check(spr_address(7, 1), m_miss);
  endtask

  task automatic test_simultaneous_events();
    logic [pcu_pkg::EVT_NUM-1:0] en_mask;
    logic [pcu_pkg::EVT_NUM-1:0] pat;
    int                          expected;
    en_mask = (1 << pcu_pkg::EVT_STORE) | (1 << pcu_pkg::EVT_IFETCH) |
              (1 << pcu_pkg::EVT_ICACHE_MISS) | (1 << pcu_pkg::EVT_DTLB_MISS);
    expected = 0;
    spr_write(spr_address(7, 10), M_CISM | M_CIUM | (32'(en_mask) << pcu_pkg::PCMR_EVT_LSB));
    spr_write(spr_address(7, 2), 32'h0);
    for (int i = 0; i < 40; i++) begin
      pat = $random(seed);
      @(negedge clk);
      evt = pat;
      if ((pat & en_mask) != '0) expected++;
    end
    pulse_events('0, 0);
    read_check(spr_address(7, 2), expected);
  endtask

  task automatic test_preset_wrap();
    spr_write(spr_address(7, 11), M_CISM | (32'(E_LOAD) << pcu_pkg::PCMR_EVT_LSB));
    spr_write(spr_address(7, 3), 32'h1234_5678);
    pulse_events(E_LOAD, 5);
    read_check(spr_address(7, 3), 32'h1234_5678 + 5);
    spr_write(spr_address(7, 3), 32'hffff_ffff);
    pulse_events(E_LOAD, 1);
    read_check(spr_address(7, 3), 32'h0);
  endtask

  task automatic test_bus_decode();
    logic [31:0] snap [16];
    for (int i = 0; i < 16; i++) spr_read(spr_address(7, i), snap[i]);
    read_check(spr_address(7, 16), 32'h0);
    for (int i = 0; i < 16; i++) read_check(spr_address(6, i), 32'h0);
    spr_write(spr_address(7, 16), 32'hffff_ffff);
    for (int i = 0; i < 16; i++) spr_write(spr_address(6, i), 32'hffff_ffff);
    for (int i = 0; i < 16; i++) read_check(spr_address(7, i), snap[i]);
  endtask

  initial begin
    #(TIMEOUT_CYC * 2 * CLK_HALF);
    $display("Run timed out after %0d clock cycles", TIMEOUT_CYC);
    $display(">>> FAIL");
    $fatal(1);
  end

  // A property of the bound checker failed at the last rising edge
  always @(negedge clk) begin
    if (i_dut.i_assert.fail_cnt != 0) begin
      $display("A concurrent assertion on the SPR port failed");
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    spr_access   = 1'b0;
    spr_we       = 1'b0;
    spr_re       = 1'b0;
    spr_addr     = '0;
    spr_dat_w    = '0;
    spr_sys_mode = 1'b1;
    evt          = '0;
    seed         = 32'he238_ca1c;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_reset_values();
    test_privilege();
    test_mode_filter();
    test_simultaneous_events();
    test_preset_wrap();
    test_bus_decode();
    if (i_dut.i_assert.fail_cnt != 0) begin
      $display("Concurrent assertions on the SPR port failed %0d times",
               i_dut.i_assert.fail_cnt);
      $display(">>> FAIL");
      $fatal(1);
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* sim.f */
verilog/pcu_pkg.sv
verilog/pcu_event_sampler.sv
verilog/pcu_event_filter.sv
verilog/pcu_counter_bank.sv
verilog/pcu_spr_regs.sv
verilog/pcu_top.sv
tests/pcu_assert.sv
tests/pcu_tb.sv
